// ==== verilog/icache_pkg.sv ====
// shared widths and controller states; a line is one 64-bit word holding exactly two instructions
package icache_pkg;

    // fetch and memory address width
    localparam int ADDR_W = 32;

    // one instruction
    localparam int INST_W = 32;

    // one cache line, equal to one memory word
    localparam int LINE_W = 64;

    // lowest set index bit; bit 2 picks the instruction half
    localparam int OFFSET_LSB = 3;

    // controller states
    // IDLE     waits for a fetch or a fence
    // LOOKUP   arrays are read at the request index
    // COMPARE  tag match, hit pulse or victim choice
    // REFILL   memory read outstanding, fill on mem_valid_i
    // FENCE    sweep of all sets clearing valid bits
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        REFILL,
        FENCE
    } ctrl_state_t;

endpackage

// ==== verilog/tag_store.sv ====
// one way; write address is the read index, and a write is visible at the read output the same edge
`timescale 1ns/1ps

module tag_store
    import icache_pkg::*;
#(
    parameter int INDEX_W = 6
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic [INDEX_W-1:0]                    rd_index_i,
    input  logic                                  wr_en_i,
    input  logic [ADDR_W-OFFSET_LSB-INDEX_W-1:0]  wr_tag_i,
    input  logic                                  wr_valid_i,
    output logic [ADDR_W-OFFSET_LSB-INDEX_W-1:0]  tag_o,
    output logic                                  valid_o
);

    localparam int TAG_W = ADDR_W - OFFSET_LSB - INDEX_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [SETS];
    logic [SETS-1:0]  valid_q;

    // tag array and read register
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[rd_index_i] <= wr_tag_i;
            tag_o               <= wr_tag_i;
        end else begin
            tag_o <= tag_mem[rd_index_i];
        end
    end

    // valid bits start cleared
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            valid_o <= 1'b0;
        end else if (wr_en_i) begin
            valid_q[rd_index_i] <= wr_valid_i;
            valid_o             <= wr_valid_i;
        end else begin
            valid_o <= valid_q[rd_index_i];
        end
    end

endmodule

// ==== verilog/line_store.sv ====
// no reset, contents undefined until filled; read output forwards same-edge write data
`timescale 1ns/1ps

module line_store
    import icache_pkg::*;
#(
    parameter int INDEX_W = 6
) (
    input  logic               clk,
    input  logic [INDEX_W-1:0] rd_index_i,
    input  logic [1:0]         wr_en_i,
    input  logic [LINE_W-1:0]  wr_data_i,
    output logic [LINE_W-1:0]  line0_o,
    output logic [LINE_W-1:0]  line1_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [LINE_W-1:0] way0_mem [SETS];
    logic [LINE_W-1:0] way1_mem [SETS];

    // way 0
    always_ff @(posedge clk) begin
        if (wr_en_i[0]) begin
            way0_mem[rd_index_i] <= wr_data_i;
            line0_o              <= wr_data_i;
        end else begin
            line0_o <= way0_mem[rd_index_i];
        end
    end

    // way 1
    always_ff @(posedge clk) begin
        if (wr_en_i[1]) begin
            way1_mem[rd_index_i] <= wr_data_i;
            line1_o              <= wr_data_i;
        end else begin
            line1_o <= way1_mem[rd_index_i];
        end
    end

endmodule

// ==== verilog/way_age_counters.sv ====
// ages read combinationally at look_index_i; a use clears the used way and ages every other counter
`timescale 1ns/1ps

module way_age_counters #(
    parameter int INDEX_W = 6,
    parameter int AGE_W   = 3
) (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               use_pulse_i,
    input  logic [INDEX_W-1:0] use_index_i,
    input  logic               use_way_i,
    input  logic [INDEX_W-1:0] look_index_i,
    output logic [AGE_W-1:0]   age0_o,
    output logic [AGE_W-1:0]   age1_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [AGE_W-1:0] age0_q [SETS];
    logic [AGE_W-1:0] age1_q [SETS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int s = 0; s < SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else if (use_pulse_i) begin
            for (int s = 0; s < SETS; s++) begin
                // saturate at all ones
                if (age0_q[s] != '1) begin
                    age0_q[s] <= age0_q[s] + 1'b1;
                end
                if (age1_q[s] != '1) begin
                    age1_q[s] <= age1_q[s] + 1'b1;
                end
            end
            // clear wins over the increment above
            if (use_way_i) begin
                age1_q[use_index_i] <= '0;
            end else begin
                age0_q[use_index_i] <= '0;
            end
        end
    end

    assign age0_o = age0_q[look_index_i];
    assign age1_o = age1_q[look_index_i];

endmodule

// ==== verilog/icache_ctrl_fsm.sv ====
// requester must hold fetch_req_i/fetch_addr_i until inst_valid_o; no accept in the cycle after it
`timescale 1ns/1ps

module icache_ctrl_fsm
    import icache_pkg::*;
#(
    parameter int INDEX_W = 6,
    parameter int AGE_W   = 3
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  logic                                  fetch_req_i,
    input  logic [ADDR_W-1:0]                     fetch_addr_i,
    input  logic                                  fence_i,
    input  logic [LINE_W-1:0]                     mem_data_i,
    input  logic                                  mem_valid_i,
    input  logic [ADDR_W-OFFSET_LSB-INDEX_W-1:0]  tag0_i,
    input  logic                                  valid0_i,
    input  logic [ADDR_W-OFFSET_LSB-INDEX_W-1:0]  tag1_i,
    input  logic                                  valid1_i,
    input  logic [LINE_W-1:0]                     line0_i,
    input  logic [LINE_W-1:0]                     line1_i,
    input  logic [AGE_W-1:0]                      age0_i,
    input  logic [AGE_W-1:0]                      age1_i,
    output logic [INST_W-1:0]                     inst_o,
    output logic                                  inst_valid_o,
    output logic                                  mem_rd_en_o,
    output logic [ADDR_W-1:0]                     mem_addr_o,
    output logic [INDEX_W-1:0]                    rd_index_o,
    output logic [1:0]                            tag_wr_en_o,
    output logic [ADDR_W-OFFSET_LSB-INDEX_W-1:0]  tag_wr_tag_o,
    output logic                                  tag_wr_valid_o,
    output logic [1:0]                            line_wr_en_o,
    output logic [LINE_W-1:0]                     line_wr_data_o,
    output logic                                  use_pulse_o,
    output logic [INDEX_W-1:0]                    use_index_o,
    output logic                                  use_way_o
);

    localparam int TAG_W = ADDR_W - OFFSET_LSB - INDEX_W;

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    // msb set once every set has been swept
    logic [INDEX_W:0]     fence_cnt_q;
    logic                 sweeping;
    logic                 valid_q;
    logic                 victim_q;
    logic                 victim;
    logic                 mem_rd_q;
    logic [INDEX_W-1:0]   req_index;
    logic [TAG_W-1:0]     req_tag;
    logic                 hit0;
    logic                 hit1;
    logic                 hit;
    logic [LINE_W-1:0]    hit_line;

    assign req_index = fetch_addr_i[OFFSET_LSB +: INDEX_W];
    assign req_tag   = fetch_addr_i[ADDR_W-1 -: TAG_W];
    assign sweeping  = (state_q == FENCE) && !fence_cnt_q[INDEX_W];

    assign hit0 = valid0_i && (tag0_i == req_tag);
    assign hit1 = valid1_i && (tag1_i == req_tag);
    assign hit  = hit0 || hit1;

    // invalid way first, way 0 preferred; then the older way, way 0 on a tie
    always_comb begin
        if (!valid0_i) begin
            victim = 1'b0;
        end else if (!valid1_i) begin
            victim = 1'b1;
        end else begin
            victim = (age1_i > age0_i);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fence_i) begin
                    state_d = FENCE;
                end else if (fetch_req_i && !valid_q) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP:  state_d = COMPARE;
            COMPARE: state_d = hit ? IDLE : REFILL;
            REFILL: begin
                if (mem_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            FENCE: begin
                if (fence_cnt_q[INDEX_W] && !fence_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= IDLE;
            fence_cnt_q <= '0;
            valid_q     <= 1'b0;
            victim_q    <= 1'b0;
            mem_rd_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            valid_q <= inst_valid_o;
            if (sweeping) begin
                fence_cnt_q <= fence_cnt_q + 1'b1;
            end else if (state_q != FENCE) begin
                fence_cnt_q <= '0;
            end
            // victim held for the whole refill
            if (state_q == COMPARE && !hit) begin
                victim_q <= victim;
                mem_rd_q <= 1'b1;
            end else if (state_q == REFILL && mem_valid_i) begin
                mem_rd_q <= 1'b0;
            end
        end
    end

    assign hit_line     = hit1 ? line1_i : line0_i;
    assign inst_o       = fetch_addr_i[OFFSET_LSB-1] ? hit_line[2*INST_W-1:INST_W]
                                                     : hit_line[INST_W-1:0];
    assign inst_valid_o = (state_q == COMPARE) && hit;

    assign mem_rd_en_o = mem_rd_q;
    assign mem_addr_o  = {fetch_addr_i[ADDR_W-1:OFFSET_LSB], {OFFSET_LSB{1'b0}}};

    // sweep index replaces the request index during a fence
    assign rd_index_o = (state_q == FENCE) ? fence_cnt_q[INDEX_W-1:0] : req_index;

    always_comb begin
        tag_wr_en_o  = 2'b00;
        line_wr_en_o = 2'b00;
        if (sweeping) begin
            tag_wr_en_o = 2'b11;
        end else if (state_q == REFILL && mem_valid_i) begin
            tag_wr_en_o[victim_q]  = 1'b1;
            line_wr_en_o[victim_q] = 1'b1;
        end
    end

    assign tag_wr_tag_o   = (state_q == FENCE) ? '0 : req_tag;
    assign tag_wr_valid_o = (state_q != FENCE);
    assign line_wr_data_o = mem_data_i;

    // age update on every completed fetch
    assign use_pulse_o = inst_valid_o;
    assign use_index_o = req_index;
    assign use_way_o   = hit1 && !hit0;

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        inst_valid_o |=> !inst_valid_o);

    a_single_way_write: assert property (@(posedge clk) disable iff (!arst_n_i)
        (state_q != FENCE) |-> (tag_wr_en_o != 2'b11));

    a_mem_rd_in_refill: assert property (@(posedge clk) disable iff (!arst_n_i)
        mem_rd_en_o |-> (state_q == REFILL));

endmodule

// ==== verilog/inst_cache_top.sv ====
// 2-way cache of 64-bit lines; hit latency 2 cycles, fence must be held for the full sweep
`timescale 1ns/1ps

module inst_cache_top
    import icache_pkg::*;
#(
    parameter int INDEX_W = 6,
    parameter int AGE_W   = 3
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              fetch_req_i,
    input  logic [ADDR_W-1:0] fetch_addr_i,
    output logic [INST_W-1:0] inst_o,
    output logic              inst_valid_o,
    input  logic              fence_i,
    output logic              mem_rd_en_o,
    output logic [ADDR_W-1:0] mem_addr_o,
    input  logic [LINE_W-1:0] mem_data_i,
    input  logic              mem_valid_i
);

    localparam int TAG_W = ADDR_W - OFFSET_LSB - INDEX_W;

    logic [INDEX_W-1:0] rd_index;
    logic [1:0]         tag_wr_en;
    logic [TAG_W-1:0]   tag_wr_tag;
    logic               tag_wr_valid;
    logic [1:0]         line_wr_en;
    logic [LINE_W-1:0]  line_wr_data;
    logic [TAG_W-1:0]   tag0;
    logic [TAG_W-1:0]   tag1;
    logic               valid0;
    logic               valid1;
    logic [LINE_W-1:0]  line0;
    logic [LINE_W-1:0]  line1;
    logic [AGE_W-1:0]   age0;
    logic [AGE_W-1:0]   age1;
    logic               use_pulse;
    logic [INDEX_W-1:0] use_index;
    logic               use_way;

    icache_ctrl_fsm #(
        .INDEX_W (INDEX_W),
        .AGE_W   (AGE_W)
    ) u_ctrl (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .fetch_req_i    (fetch_req_i),
        .fetch_addr_i   (fetch_addr_i),
        .fence_i        (fence_i),
        .mem_data_i     (mem_data_i),
        .mem_valid_i    (mem_valid_i),
        .tag0_i         (tag0),
        .valid0_i       (valid0),
        .tag1_i         (tag1),
        .valid1_i       (valid1),
        .line0_i        (line0),
        .line1_i        (line1),
        .age0_i         (age0),
        .age1_i         (age1),
        .inst_o         (inst_o),
        .inst_valid_o   (inst_valid_o),
        .mem_rd_en_o    (mem_rd_en_o),
        .mem_addr_o     (mem_addr_o),
        .rd_index_o     (rd_index),
        .tag_wr_en_o    (tag_wr_en),
        .tag_wr_tag_o   (tag_wr_tag),
        .tag_wr_valid_o (tag_wr_valid),
        .line_wr_en_o   (line_wr_en),
        .line_wr_data_o (line_wr_data),
        .use_pulse_o    (use_pulse),
        .use_index_o    (use_index),
        .use_way_o      (use_way)
    );

    // ages are looked up at the request index
    way_age_counters #(
        .INDEX_W (INDEX_W),
        .AGE_W   (AGE_W)
    ) u_age (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .use_pulse_i  (use_pulse),
        .use_index_i  (use_index),
        .use_way_i    (use_way),
        .look_index_i (use_index),
        .age0_o       (age0),
        .age1_o       (age1)
    );

    tag_store #(
        .INDEX_W (INDEX_W)
    ) u_tag0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd_index_i (rd_index),
        .wr_en_i    (tag_wr_en[0]),
        .wr_tag_i   (tag_wr_tag),
        .wr_valid_i (tag_wr_valid),
        .tag_o      (tag0),
        .valid_o    (valid0)
    );

    tag_store #(
        .INDEX_W (INDEX_W)
    ) u_tag1 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .rd_index_i (rd_index),
        .wr_en_i    (tag_wr_en[1]),
        .wr_tag_i   (tag_wr_tag),
        .wr_valid_i (tag_wr_valid),
        .tag_o      (tag1),
        .valid_o    (valid1)
    );

    line_store #(
        .INDEX_W (INDEX_W)
    ) u_lines (
        .clk        (clk),
        .rd_index_i (rd_index),
        .wr_en_i    (line_wr_en),
        .wr_data_i  (line_wr_data),
        .line0_o    (line0),
        .line1_o    (line1)
    );

endmodule

// ==== test/tb_inst_cache.sv ====
// default 64-set, 3-bit-age build only; random fetches stay in sets 0-3 with tags 0-3
`timescale 1ns/1ps

module tb_inst_cache
    import icache_pkg::*;
();

    localparam int INDEX_W        = 6;
    localparam int AGE_W          = 3;
    localparam int SETS           = 1 << INDEX_W;
    localparam int TAG_W          = ADDR_W - OFFSET_LSB - INDEX_W;
    localparam int AGE_MAX        = (1 << AGE_W) - 1;
    localparam int CLK_PERIOD     = 4;
    localparam int N_DIRECTED     = 12;
    localparam int N_RANDOM       = 40;
    localparam int N_ROWS         = N_DIRECTED + N_RANDOM;
    localparam int TIMEOUT_CYCLES = N_ROWS * 16 + 3 * 64 + 100;
    // one edge to sample the request, two more to the pulse
    localparam int HIT_EDGES      = 3;
    localparam logic [31:0] SEED  = 32'h432d_1f6f;

    typedef struct {
        bit                is_fence;
        logic [ADDR_W-1:0] addr;
        // 1 miss, 0 hit, -1 from the reference model
        int                exp_miss;
    } row_t;

    logic              clk;
    logic              arst_n_i;
    logic              fetch_req_i;
    logic [ADDR_W-1:0] fetch_addr_i;
    logic [INST_W-1:0] inst_o;
    logic              inst_valid_o;
    logic              fence_i;
    logic              mem_rd_en_o;
    logic [ADDR_W-1:0] mem_addr_o;
    logic [LINE_W-1:0] mem_data_i;
    logic              mem_valid_i;

    logic [31:0]       rng_state;
    logic [ADDR_W-1:0] last_mem_addr;
    int                mem_reads;
    int                err_cnt;
    int                rows_pass;
    int                rows_fail;
    int                cycle_cnt;
    row_t              stim_q[$];

    // reference model of tags, valid bits and ages
    logic [TAG_W-1:0]  ref_tag   [SETS][2];
    bit                ref_valid [SETS][2];
    int                ref_age   [SETS][2];

    inst_cache_top #(
        .INDEX_W (INDEX_W),
        .AGE_W   (AGE_W)
    ) dut0 (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .inst_o       (inst_o),
        .inst_valid_o (inst_valid_o),
        .fence_i      (fence_i),
        .mem_rd_en_o  (mem_rd_en_o),
        .mem_addr_o   (mem_addr_o),
        .mem_data_i   (mem_data_i),
        .mem_valid_i  (mem_valid_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // memory contents are a hash of the line address
    function automatic logic [LINE_W-1:0] mem_word(input logic [ADDR_W-1:0] line_addr);
        return {xorshift32(line_addr ^ 32'h5bd1_e995), xorshift32(line_addr ^ 32'h1b87_3593)};
    endfunction

    function automatic logic [INST_W-1:0] expected_inst(input logic [ADDR_W-1:0] addr);
        logic [LINE_W-1:0] word;
        word = mem_word({addr[ADDR_W-1:OFFSET_LSB], {OFFSET_LSB{1'b0}}});
        return addr[OFFSET_LSB-1] ? word[2*INST_W-1:INST_W] : word[INST_W-1:0];
    endfunction

    // lookup, victim fill and age update for one completed fetch
    function automatic bit model_fetch(input logic [ADDR_W-1:0] addr);
        int               idx;
        int               way;
        bit               miss;
        logic [TAG_W-1:0] tag;
        idx  = int'(addr[OFFSET_LSB +: INDEX_W]);
        tag  = addr[ADDR_W-1 -: TAG_W];
        miss = 1'b0;
        if (ref_valid[idx][0] && ref_tag[idx][0] == tag) begin
            way = 0;
        end else if (ref_valid[idx][1] && ref_tag[idx][1] == tag) begin
            way = 1;
        end else begin
            miss = 1'b1;
            if (!ref_valid[idx][0]) begin
                way = 0;
            end else if (!ref_valid[idx][1]) begin
                way = 1;
            end else begin
                way = (ref_age[idx][1] > ref_age[idx][0]) ? 1 : 0;
            end
            ref_valid[idx][way] = 1'b1;
            ref_tag[idx][way]   = tag;
        end
        // every counter ages and the used one restarts
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (ref_age[s][w] < AGE_MAX) begin
                    ref_age[s][w]++;
                end
            end
        end
        ref_age[idx][way] = 0;
        return miss;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic add_row(input bit is_fence, input logic [ADDR_W-1:0] addr, input int exp_miss);
        row_t row;
        row.is_fence = is_fence;
        row.addr     = addr;
        row.exp_miss = exp_miss;
        stim_q.push_back(row);
    endtask

    task automatic build_table();
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        // cold miss, then the other half hits
        add_row(1'b0, 32'h0000_1000, 1);
        add_row(1'b0, 32'h0000_1004, 0);
        // set 5 with A, B, A, C where C evicts the older B
        add_row(1'b0, 32'h0000_2028, 1);
        add_row(1'b0, 32'h0000_4028, 1);
        add_row(1'b0, 32'h0000_2028, 0);
        add_row(1'b0, 32'h0000_6028, 1);
        add_row(1'b0, 32'h0000_202c, 0);
        add_row(1'b0, 32'h0000_4028, 1);
        // everything misses again after the sweep
        add_row(1'b1, 32'h0000_0000, -1);
        add_row(1'b0, 32'h0000_1004, 1);
        add_row(1'b0, 32'h0000_1000, 0);
        add_row(1'b0, 32'h0000_202c, 1);
        for (int n = 0; n < N_RANDOM; n++) begin
            r    = next_rand();
            addr = {21'd0, r[1:0], 4'd0, r[3:2], r[4], 2'b00};
            add_row(1'b0, addr, -1);
        end
    endtask

    task automatic run_fetch(input logic [ADDR_W-1:0] addr, output logic [INST_W-1:0] inst,
                             output int edges, output int reads);
        int start_reads;
        start_reads = mem_reads;
        @(posedge clk);
        fetch_req_i  <= 1'b1;
        fetch_addr_i <= addr;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (!inst_valid_o);
        inst = inst_o;
        fetch_req_i <= 1'b0;
        reads = mem_reads - start_reads;
    endtask

    task automatic run_fence();
        @(posedge clk);
        fence_i <= 1'b1;
        repeat (SETS + 4) @(posedge clk);
        fence_i <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // answers each read after 1 to 4 cycles
    initial begin : memory_model
        int delay;
        forever begin
            @(posedge clk);
            if (mem_rd_en_o) begin
                last_mem_addr = mem_addr_o;
                delay = 1 + int'(next_rand() % 4);
                repeat (delay - 1) @(posedge clk);
                mem_data_i  <= mem_word(mem_addr_o);
                mem_valid_i <= 1'b1;
                mem_reads++;
                @(posedge clk);
                mem_valid_i <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the DUT stopped responding within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        row_t              row;
        logic [INST_W-1:0] inst;
        int                edges;
        int                reads;
        int                exp_miss;
        int                err_before;
        arst_n_i      = 1'b0;
        fetch_req_i   = 1'b0;
        fetch_addr_i  = '0;
        fence_i       = 1'b0;
        mem_data_i    = '0;
        mem_valid_i   = 1'b0;
        rng_state     = SEED;
        last_mem_addr = '0;
        mem_reads     = 0;
        err_cnt       = 0;
        rows_pass     = 0;
        rows_fail     = 0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                ref_valid[s][w] = 1'b0;
                ref_tag[s][w]   = '0;
                ref_age[s][w]   = 0;
            end
        end
        build_table();
        repeat (3) @(posedge clk);
        arst_n_i <= 1'b1;

        foreach (stim_q[i]) begin
            row        = stim_q[i];
            err_before = err_cnt;
            if (row.is_fence) begin
                run_fence();
                for (int s = 0; s < SETS; s++) begin
                    ref_valid[s][0] = 1'b0;
                    ref_valid[s][1] = 1'b0;
                end
                $display("row %0d fence %s", i, (err_cnt == err_before) ? "ok" : "fail");
            end else begin
                exp_miss = int'(model_fetch(row.addr));
                if (row.exp_miss >= 0) begin
                    exp_miss = row.exp_miss;
                end
                run_fetch(row.addr, inst, edges, reads);
                check_value(reads, exp_miss, $sformatf("row %0d memory reads", i));
                if (exp_miss != 0) begin
                    check_value(last_mem_addr, {row.addr[ADDR_W-1:OFFSET_LSB], 3'b000},
                                $sformatf("row %0d memory address", i));
                end else begin
                    check_value(edges, HIT_EDGES, $sformatf("row %0d hit latency", i));
                end
                check_value(inst, expected_inst(row.addr), $sformatf("row %0d instruction", i));
                $display("row %0d fetch %h miss %0d edges %0d %s", i, row.addr, exp_miss, edges,
                         (err_cnt == err_before) ? "ok" : "fail");
            end
            if (err_cnt == err_before) begin
                rows_pass++;
            end else begin
                rows_fail++;
            end
        end

        $display("summary: %0d rows passed, %0d rows failed, %0d errors",
                 rows_pass, rows_fail, err_cnt);
        if (err_cnt == 0 && rows_fail == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/icache_pkg.sv
verilog/tag_store.sv
verilog/line_store.sv
verilog/way_age_counters.sv
verilog/icache_ctrl_fsm.sv
verilog/inst_cache_top.sv
test/tb_inst_cache.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_inst_cache -f sim.f -Mdir obj_dir -o sim_inst_cache

./obj_dir/sim_inst_cache > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
